// File: lsb_pkg.sv
package lsb_pkg;

    localparam int XLEN       = 32;
    localparam int TAG_W      = 5;   // tag 0 = no dependency
    localparam int LSB_DEPTH  = 16;
    localparam int PTR_W      = 4;
    localparam int FULL_SLACK = 3;   // free entries left when lsb_full rises
    localparam int OP_W       = 3;

    // operation codes
    localparam logic [OP_W-1:0] OP_LB  = 3'd0;
    localparam logic [OP_W-1:0] OP_LH  = 3'd1;
    localparam logic [OP_W-1:0] OP_LW  = 3'd2;
    localparam logic [OP_W-1:0] OP_LBU = 3'd3;
    localparam logic [OP_W-1:0] OP_LHU = 3'd4;
    localparam logic [OP_W-1:0] OP_SB  = 3'd5;
    localparam logic [OP_W-1:0] OP_SH  = 3'd6;
    localparam logic [OP_W-1:0] OP_SW  = 3'd7;

    // queue entry state
    localparam logic [1:0] ST_EMPTY  = 2'd0;
    localparam logic [1:0] ST_WAIT   = 2'd1;  // operand outstanding
    localparam logic [1:0] ST_READY  = 2'd2;
    localparam logic [1:0] ST_COMMIT = 2'd3;  // store released by the ROB

    // data word, seen whole or as little-endian bytes
    typedef union packed {
        logic [XLEN-1:0]         word;
        logic [XLEN/8-1:0][7:0]  bytes;
    } lsb_word_t;

endpackage

// File: lsb_queue.sv
`timescale 1ns/1ns

module lsb_queue
    import lsb_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             flush,
    input  logic             dispatch_valid,
    input  logic [OP_W-1:0]  dispatch_op,
    input  logic [TAG_W-1:0] dispatch_tag,
    input  logic [XLEN-1:0]  rs1_value,
    input  logic [TAG_W-1:0] rs1_tag,
    input  logic [XLEN-1:0]  rs2_value,
    input  logic [TAG_W-1:0] rs2_tag,
    input  logic [XLEN-1:0]  imm,
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]  cdb_value,
    input  logic             store_commit,
    input  logic             head_ready,
    output logic             lsb_full,
    output logic             head_valid,
    output logic [OP_W-1:0]  head_op,
    output logic [TAG_W-1:0] head_tag,
    output logic [XLEN-1:0]  head_rs1,
    output logic [XLEN-1:0]  head_rs2,
    output logic [XLEN-1:0]  head_imm
);

    logic [OP_W-1:0]  ent_op      [LSB_DEPTH];
    logic [TAG_W-1:0] ent_tag     [LSB_DEPTH];
    logic [XLEN-1:0]  ent_rs1     [LSB_DEPTH];
    logic [TAG_W-1:0] ent_rs1_tag [LSB_DEPTH];
    logic [XLEN-1:0]  ent_rs2     [LSB_DEPTH];
    logic [TAG_W-1:0] ent_rs2_tag [LSB_DEPTH];
    logic [XLEN-1:0]  ent_imm     [LSB_DEPTH];
    logic [1:0]       ent_st      [LSB_DEPTH];

    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     wptr;
    logic [PTR_W-1:0]     commit_ptr;
    logic [PTR_W:0]       used_cnt;
    logic [PTR_W:0]       commit_cnt;
    logic [LSB_DEPTH-1:0] hit1;
    logic [LSB_DEPTH-1:0] hit2;
    logic                 d_hit1;
    logic                 d_hit2;
    logic                 head_is_load;
    logic                 pop;

    always_comb begin
        used_cnt   = '0;
        commit_cnt = '0;
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (ent_st[i] != ST_EMPTY)
                used_cnt = used_cnt + 1'b1;
            if (ent_st[i] == ST_COMMIT)
                commit_cnt = commit_cnt + 1'b1;
            hit1[i] = cdb_valid && (ent_rs1_tag[i] != '0) && (ent_rs1_tag[i] == cdb_tag);
            hit2[i] = cdb_valid && (ent_rs2_tag[i] != '0) && (ent_rs2_tag[i] == cdb_tag);
        end
    end

    // committed stores sit together at the head
    assign wptr       = head + used_cnt[PTR_W-1:0];
    assign commit_ptr = head + commit_cnt[PTR_W-1:0];
    assign lsb_full   = used_cnt >= LSB_DEPTH - FULL_SLACK;

    // broadcast in the dispatch cycle
    assign d_hit1 = cdb_valid && (rs1_tag != '0) && (rs1_tag == cdb_tag);
    assign d_hit2 = cdb_valid && (rs2_tag != '0) && (rs2_tag == cdb_tag);

    assign head_op      = ent_op[head];
    assign head_tag     = ent_tag[head];
    assign head_rs1     = ent_rs1[head];
    assign head_rs2     = ent_rs2[head];
    assign head_imm     = ent_imm[head];
    assign head_is_load = (head_op != OP_SB) && (head_op != OP_SH) && (head_op != OP_SW);
    assign head_valid   = head_is_load ? (ent_st[head] == ST_READY) :
                          (ent_st[head] == ST_COMMIT && ent_rs1_tag[head] == '0 &&
                           ent_rs2_tag[head] == '0);
    assign pop = head_valid && head_ready;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head <= '0;
            for (int i = 0; i < LSB_DEPTH; i++)
                ent_st[i] <= ST_EMPTY;
        end else begin
            for (int i = 0; i < LSB_DEPTH; i++) begin
                if (hit1[i]) begin
                    ent_rs1[i]     <= cdb_value;
                    ent_rs1_tag[i] <= '0;
                end
                if (hit2[i]) begin
                    ent_rs2[i]     <= cdb_value;
                    ent_rs2_tag[i] <= '0;
                end
                if (ent_st[i] == ST_WAIT && (ent_rs1_tag[i] == '0 || hit1[i]) &&
                    (ent_rs2_tag[i] == '0 || hit2[i]))
                    ent_st[i] <= ST_READY;
            end

            if (store_commit)
                ent_st[commit_ptr] <= ST_COMMIT;  // oldest uncommitted

            if (dispatch_valid && !flush) begin
                ent_op[wptr]      <= dispatch_op;
                ent_tag[wptr]     <= dispatch_tag;
                ent_imm[wptr]     <= imm;
                ent_rs1[wptr]     <= d_hit1 ? cdb_value : rs1_value;
                ent_rs1_tag[wptr] <= d_hit1 ? '0 : rs1_tag;
                ent_rs2[wptr]     <= d_hit2 ? cdb_value : rs2_value;
                ent_rs2_tag[wptr] <= d_hit2 ? '0 : rs2_tag;
                if ((rs1_tag == '0 || d_hit1) && (rs2_tag == '0 || d_hit2))
                    ent_st[wptr] <= ST_READY;
                else
                    ent_st[wptr] <= ST_WAIT;
            end

            if (pop) begin
                ent_st[head] <= ST_EMPTY;
                head         <= head + 1'b1;
            end

            // only committed stores survive, including one committed right now
            if (flush) begin
                for (int i = 0; i < LSB_DEPTH; i++) begin
                    if (ent_st[i] != ST_COMMIT &&
                        !(store_commit && PTR_W'(i) == commit_ptr))
                        ent_st[i] <= ST_EMPTY;
                end
            end
        end
    end

endmodule

// File: lsb_issue.sv
`timescale 1ns/1ns

module lsb_issue
    import lsb_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             flush,
    input  logic             head_valid,
    input  logic [OP_W-1:0]  head_op,
    input  logic [TAG_W-1:0] head_tag,
    input  logic [XLEN-1:0]  head_rs1,
    input  logic [XLEN-1:0]  head_rs2,
    input  logic [XLEN-1:0]  head_imm,
    input  logic             seq_ready,
    output logic             head_ready,
    output logic             iss_valid,
    output logic [OP_W-1:0]  iss_op,
    output logic [TAG_W-1:0] iss_tag,
    output logic [XLEN-1:0]  iss_addr,
    output logic [XLEN-1:0]  iss_wdata
);

    logic head_is_load;
    logic iss_is_load;

    assign head_is_load = (head_op != OP_SB) && (head_op != OP_SH) && (head_op != OP_SW);
    assign iss_is_load  = (iss_op != OP_SB) && (iss_op != OP_SH) && (iss_op != OP_SW);

    // free, or current op leaves this cycle
    assign head_ready = !iss_valid || seq_ready;

    always_ff @(posedge clk_in) begin
        if (rst_in)
            iss_valid <= 1'b0;
        else if (head_valid && head_ready)
            iss_valid <= !(flush && head_is_load);  // a load taken during flush is dropped
        else if (seq_ready || (flush && iss_is_load))
            iss_valid <= 1'b0;
    end

    always_ff @(posedge clk_in) begin
        if (head_valid && head_ready) begin
            iss_op    <= head_op;
            iss_tag   <= head_tag;
            iss_addr  <= head_rs1 + head_imm;
            iss_wdata <= head_rs2;
        end
    end

endmodule

// File: lsb_mem_seq.sv
`timescale 1ns/1ns

module lsb_mem_seq
    import lsb_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             flush,
    input  logic             iss_valid,
    input  logic [OP_W-1:0]  iss_op,
    input  logic [TAG_W-1:0] iss_tag,
    input  logic [XLEN-1:0]  iss_addr,
    input  logic [XLEN-1:0]  iss_wdata,
    input  logic [7:0]       mem_rdata,
    output logic             seq_ready,
    output logic             mem_req,
    output logic             mem_we,
    output logic [XLEN-1:0]  mem_addr,
    output logic [7:0]       mem_wdata,
    output logic             load_done,
    output logic [OP_W-1:0]  load_op,
    output logic [TAG_W-1:0] load_tag,
    output lsb_word_t        load_word
);

    logic      busy;
    logic      cur_store;
    logic [1:0] byte_idx;   // byte of the current request
    logic [1:0] last_idx;   // access size minus one
    logic      rd_valid;    // read issued last cycle
    logic [1:0] rd_idx;
    logic      rd_last;
    lsb_word_t st_word;
    logic      iss_is_store;
    logic      accept;

    assign seq_ready    = !busy;
    assign iss_is_store = (iss_op == OP_SB) || (iss_op == OP_SH) || (iss_op == OP_SW);
    assign accept       = iss_valid && seq_ready && !(flush && !iss_is_store);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy      <= 1'b0;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
            rd_valid  <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            rd_valid  <= mem_req && !mem_we;
            rd_idx    <= byte_idx;
            rd_last   <= byte_idx == last_idx;

            if (mem_req) begin
                if (byte_idx == last_idx) begin
                    mem_req <= 1'b0;
                    mem_we  <= 1'b0;
                    if (cur_store)
                        busy <= 1'b0;  // stores are done after the last write
                end else begin
                    byte_idx  <= byte_idx + 2'd1;
                    mem_addr  <= mem_addr + 1'b1;
                    mem_wdata <= st_word.bytes[byte_idx + 2'd1];
                end
            end

            if (rd_valid) begin
                load_word.bytes[rd_idx] <= mem_rdata;
                if (rd_last) begin
                    busy      <= 1'b0;
                    load_done <= 1'b1;
                end
            end

            if (accept) begin
                busy         <= 1'b1;
                cur_store    <= iss_is_store;
                mem_req      <= 1'b1;
                mem_we       <= iss_is_store;
                mem_addr     <= iss_addr;
                mem_wdata    <= iss_wdata[7:0];
                st_word.word <= iss_wdata;
                byte_idx     <= 2'd0;
                case (iss_op)
                    OP_LH, OP_LHU, OP_SH: last_idx <= 2'd1;
                    OP_LW, OP_SW:         last_idx <= 2'd3;
                    default:              last_idx <= 2'd0;
                endcase
                if (!iss_is_store) begin
                    load_op  <= iss_op;
                    load_tag <= iss_tag;
                end
            end

            // abandon a load in flight, stores run to the end
            if (flush && busy && !cur_store) begin
                busy      <= 1'b0;
                mem_req   <= 1'b0;
                rd_valid  <= 1'b0;
                load_done <= 1'b0;
            end
        end
    end

endmodule

// File: lsb_load_format.sv
`timescale 1ns/1ns

module lsb_load_format
    import lsb_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             load_done,
    input  logic [OP_W-1:0]  load_op,
    input  logic [TAG_W-1:0] load_tag,
    input  lsb_word_t        load_word,
    output logic             result_valid,
    output logic [TAG_W-1:0] result_tag,
    output logic [XLEN-1:0]  result_data
);

    always_ff @(posedge clk_in) begin
        if (rst_in)
            result_valid <= 1'b0;
        else
            result_valid <= load_done;
    end

    always_ff @(posedge clk_in) begin
        result_tag <= load_tag;
        case (load_op)
            OP_LB:   result_data <= {{(XLEN-8){load_word.bytes[0][7]}}, load_word.bytes[0]};
            OP_LH:   result_data <= {{(XLEN-16){load_word.bytes[1][7]}},
                                     load_word.bytes[1], load_word.bytes[0]};
            OP_LBU:  result_data <= {{(XLEN-8){1'b0}}, load_word.bytes[0]};
            OP_LHU:  result_data <= {{(XLEN-16){1'b0}}, load_word.bytes[1], load_word.bytes[0]};
            default: result_data <= load_word.word;  // LW
        endcase
    end

endmodule

// File: lsb_top.sv
`timescale 1ns/1ns

module lsb_top
    import lsb_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             dispatch_valid,
    input  logic [OP_W-1:0]  dispatch_op,
    input  logic [TAG_W-1:0] dispatch_tag,
    input  logic [XLEN-1:0]  rs1_value,
    input  logic [TAG_W-1:0] rs1_tag,
    input  logic [XLEN-1:0]  rs2_value,
    input  logic [TAG_W-1:0] rs2_tag,
    input  logic [XLEN-1:0]  imm,
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]  cdb_value,
    input  logic             store_commit,
    input  logic             flush,
    output logic             lsb_full,
    output logic             mem_req,
    output logic             mem_we,
    output logic [XLEN-1:0]  mem_addr,
    output logic [7:0]       mem_wdata,
    input  logic [7:0]       mem_rdata,
    output logic             result_valid,
    output logic [TAG_W-1:0] result_tag,
    output logic [XLEN-1:0]  result_data
);

    logic             head_valid;
    logic             head_ready;
    logic [OP_W-1:0]  head_op;
    logic [TAG_W-1:0] head_tag;
    logic [XLEN-1:0]  head_rs1;
    logic [XLEN-1:0]  head_rs2;
    logic [XLEN-1:0]  head_imm;
    logic             iss_valid;
    logic             seq_ready;
    logic [OP_W-1:0]  iss_op;
    logic [TAG_W-1:0] iss_tag;
    logic [XLEN-1:0]  iss_addr;
    logic [XLEN-1:0]  iss_wdata;
    logic             load_done;
    logic [OP_W-1:0]  load_op;
    logic [TAG_W-1:0] load_tag;
    lsb_word_t        load_word;

    lsb_queue lsb_queue_i (
        .clk_in, .rst_in, .flush,
        .dispatch_valid, .dispatch_op, .dispatch_tag,
        .rs1_value, .rs1_tag, .rs2_value, .rs2_tag, .imm,
        .cdb_valid, .cdb_tag, .cdb_value,
        .store_commit, .head_ready, .lsb_full,
        .head_valid, .head_op, .head_tag, .head_rs1, .head_rs2, .head_imm
    );

    lsb_issue lsb_issue_i (
        .clk_in, .rst_in, .flush,
        .head_valid, .head_op, .head_tag, .head_rs1, .head_rs2, .head_imm,
        .seq_ready, .head_ready,
        .iss_valid, .iss_op, .iss_tag, .iss_addr, .iss_wdata
    );

    lsb_mem_seq lsb_mem_seq_i (
        .clk_in, .rst_in, .flush,
        .iss_valid, .iss_op, .iss_tag, .iss_addr, .iss_wdata,
        .mem_rdata, .seq_ready,
        .mem_req, .mem_we, .mem_addr, .mem_wdata,
        .load_done, .load_op, .load_tag, .load_word
    );

    lsb_load_format lsb_load_format_i (
        .clk_in, .rst_in,
        .load_done, .load_op, .load_tag, .load_word,
        .result_valid, .result_tag, .result_data
    );

endmodule

// File: tb_lsb.sv
`timescale 1ns/1ns

module tb_lsb
    import lsb_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int N_RAND_LOADS = 40;
    localparam int N_OPS        = N_RAND_LOADS + 26;  // directed tests add 26 ops
    localparam int MEM_SIZE     = 256;

    logic             clk_in;
    logic             rst_in;
    logic             dispatch_valid;
    logic [OP_W-1:0]  dispatch_op;
    logic [TAG_W-1:0] dispatch_tag;
    logic [XLEN-1:0]  rs1_value;
    logic [TAG_W-1:0] rs1_tag;
    logic [XLEN-1:0]  rs2_value;
    logic [TAG_W-1:0] rs2_tag;
    logic [XLEN-1:0]  imm;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0]  cdb_value;
    logic             store_commit;
    logic             flush;
    logic             lsb_full;
    logic             mem_req;
    logic             mem_we;
    logic [XLEN-1:0]  mem_addr;
    logic [7:0]       mem_wdata;
    logic [7:0]       mem_rdata;
    logic             result_valid;
    logic [TAG_W-1:0] result_tag;
    logic [XLEN-1:0]  result_data;

    logic [7:0]            mem_model [MEM_SIZE];
    logic [7:0]            shadow    [MEM_SIZE];  // expected memory contents
    logic [TAG_W+XLEN-1:0] exp_q     [$];         // {tag, data} in issue order
    integer                seed;
    logic [TAG_W-1:0]      next_tag;
    logic [TAG_W-1:0]      last_tag;
    logic [XLEN-1:0]       last_imm;

    lsb_top lsb_top_i (.*);

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // byte memory, read data one cycle after the request
    always @(posedge clk_in) begin
        if (mem_req && mem_we)
            mem_model[mem_addr[7:0]] <= mem_wdata;
        if (mem_req)
            mem_rdata <= mem_model[mem_addr[7:0]];
    end

    function automatic logic [XLEN-1:0] load_ref(input logic [OP_W-1:0] op,
                                                 input logic [XLEN-1:0] addr);
        logic [7:0] b [4];
        for (int i = 0; i < 4; i++)
            b[i] = shadow[(addr[7:0] + i) % MEM_SIZE];  // little-endian
        case (op)
            OP_LB:   load_ref = {{24{b[0][7]}}, b[0]};
            OP_LH:   load_ref = {{16{b[1][7]}}, b[1], b[0]};
            OP_LBU:  load_ref = {24'h0, b[0]};
            OP_LHU:  load_ref = {16'h0, b[1], b[0]};
            default: load_ref = {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    function automatic logic [OP_W-1:0] random_load_op();
        case ($unsigned($random(seed)) % 5)
            0:       random_load_op = OP_LB;
            1:       random_load_op = OP_LH;
            2:       random_load_op = OP_LW;
            3:       random_load_op = OP_LBU;
            default: random_load_op = OP_LHU;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // base is split into rs1 + imm with a random offset
    task automatic send_op(input logic [OP_W-1:0] op, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] data, input logic [TAG_W-1:0] base_tag,
                           input bit expect_result);
        logic [XLEN-1:0] offs;
        offs = $random(seed);
        @(negedge clk_in);
        while (lsb_full)
            @(negedge clk_in);
        @(posedge clk_in);
        dispatch_valid <= 1'b1;
        dispatch_op    <= op;
        dispatch_tag   <= next_tag;
        imm            <= offs;
        rs1_value      <= (base_tag == '0) ? addr - offs : ~(addr - offs);  // stale base
        rs1_tag        <= base_tag;
        rs2_value      <= data;
        rs2_tag        <= '0;
        @(posedge clk_in);
        dispatch_valid <= 1'b0;
        if (expect_result)
            exp_q.push_back({next_tag, load_ref(op, addr)});
        last_tag = next_tag;
        last_imm = offs;
        next_tag = (next_tag == '1) ? TAG_W'(1) : next_tag + 1'b1;
    endtask

    task automatic commit_store(input logic [OP_W-1:0] op, input logic [XLEN-1:0] addr,
                                input logic [XLEN-1:0] data);
        int n;
        n = (op == OP_SW) ? 4 : (op == OP_SH) ? 2 : 1;
        @(posedge clk_in);
        store_commit <= 1'b1;
        @(posedge clk_in);
        store_commit <= 1'b0;
        for (int i = 0; i < n; i++)
            shadow[(addr[7:0] + i) % MEM_SIZE] = data[8*i +: 8];
    endtask

    task automatic pulse_flush();
        @(posedge clk_in);
        flush <= 1'b1;
        @(posedge clk_in);
        flush <= 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0)
            @(negedge clk_in);
    endtask

    task automatic compare_memory();
        for (int i = 0; i < MEM_SIZE; i++)
            check_value($sformatf("mem_model[%0d]", i), 32'(mem_model[i]), 32'(shadow[i]));
    endtask

    always @(negedge clk_in) begin : compare_results
        logic [TAG_W+XLEN-1:0] want;
        if (!rst_in && result_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("result_valid went high with no load outstanding");
            end else begin
                want = exp_q.pop_front();
                check_value("result_tag", 32'(result_tag), 32'(want[TAG_W+XLEN-1:XLEN]));
                check_value("result_data", result_data, want[XLEN-1:0]);
            end
        end
    end

    initial begin
        #(N_OPS * 12 * CLK_PERIOD + 200 * CLK_PERIOD);
        $display("timeout, the tests did not finish in the expected time");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : run_tests
        logic [OP_W-1:0] op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        int count;
        seed           = 32'ha77d_f669;
        next_tag       = TAG_W'(1);
        rst_in         = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = '0;
        dispatch_tag   = '0;
        rs1_value      = '0;
        rs1_tag        = '0;
        rs2_value      = '0;
        rs2_tag        = '0;
        imm            = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        store_commit   = 1'b0;
        flush          = 1'b0;
        mem_rdata      = '0;
        for (int i = 0; i < MEM_SIZE; i++) begin
            mem_model[i] = 8'($random(seed));
            shadow[i]    = mem_model[i];
        end
        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;

        // random loads of every kind
        for (int i = 0; i < N_RAND_LOADS; i++) begin
            op = random_load_op();
            a  = $random(seed) & 32'hff;
            send_op(op, a, 32'h0, '0, 1'b1);
        end
        wait_results();

        // store of each size, commit, read back
        for (int i = 0; i < 3; i++) begin
            op = (i == 0) ? OP_SB : (i == 1) ? OP_SH : OP_SW;
            a  = $random(seed) & 32'h7f;
            d  = $random(seed);
            send_op(op, a, d, '0, 1'b0);
            commit_store(op, a, d);
            send_op((i == 0) ? OP_LBU : (i == 1) ? OP_LHU : OP_LW, a, 32'h0, '0, 1'b1);
            wait_results();
        end
        compare_memory();

        // base operand woken by a broadcast
        a = $random(seed) & 32'hff;
        send_op(OP_LW, a, 32'h0, TAG_W'(9), 1'b0);
        repeat (10) @(negedge clk_in);
        @(posedge clk_in);
        cdb_valid <= 1'b1;
        cdb_tag   <= TAG_W'(9);
        cdb_value <= a - last_imm;
        exp_q.push_back({last_tag, load_ref(OP_LW, a)});
        @(posedge clk_in);
        cdb_valid <= 1'b0;
        wait_results();

        // flush behind a committed and an uncommitted store
        d = $random(seed);
        send_op(OP_SW, 32'he0, d, '0, 1'b0);
        send_op(OP_SW, 32'he8, ~d, '0, 1'b0);
        send_op(OP_LW, $random(seed) & 32'h7f, 32'h0, '0, 1'b0);
        send_op(OP_LB, $random(seed) & 32'h7f, 32'h0, '0, 1'b0);
        commit_store(OP_SW, 32'he0, d);
        pulse_flush();
        repeat (30) @(negedge clk_in);  // flushed loads must stay silent
        send_op(OP_LW, 32'he0, 32'h0, '0, 1'b1);
        send_op(OP_LW, 32'he8, 32'h0, '0, 1'b1);
        wait_results();
        compare_memory();

        // fill behind a held store and watch lsb_full
        d = $random(seed);
        send_op(OP_SW, 32'hc0, d, '0, 1'b0);
        for (count = 1; count <= LSB_DEPTH - FULL_SLACK; count++) begin
            @(negedge clk_in);
            check_value("lsb_full", 32'(lsb_full), 32'(count >= LSB_DEPTH - FULL_SLACK));
            if (count < LSB_DEPTH - FULL_SLACK)
                send_op(random_load_op(), $random(seed) & 32'h7f, 32'h0, '0, 1'b1);
        end
        repeat (5) begin
            @(negedge clk_in);
            check_value("lsb_full", 32'(lsb_full), 32'h1);
        end
        commit_store(OP_SW, 32'hc0, d);
        wait_results();
        @(negedge clk_in);
        check_value("lsb_full", 32'(lsb_full), 32'h0);
        compare_memory();

        $display("test passed");
        $finish;
    end

endmodule

// File: compile.f
lsb_pkg.sv
lsb_queue.sv
lsb_issue.sv
lsb_mem_seq.sv
lsb_load_format.sv
lsb_top.sv
tb_lsb.sv
